//--- include/hdu_config.svh
// slot ids are plain binary, so HDU_SLOTS must equal 2**HDU_SLOT_ID_W for the wrap-around scan
`ifndef HDU_CONFIG_SVH
`define HDU_CONFIG_SVH

// architectural register file
`define HDU_REG_ADDR_W 5

// scoreboard geometry
`define HDU_SLOTS      8
`define HDU_SLOT_ID_W  3

// issue needs this many free slots, enough for a full pair
`define HDU_MIN_FREE   2

// execution unit codes, carried as a 2-bit field
`define HDU_EXU_W      2
`define HDU_EXU_ALU    2'd0
`define HDU_EXU_MUL    2'd1
`define HDU_EXU_DIV    2'd2
`define HDU_EXU_CSR    2'd3

`endif

//--- rtl/hdu_pkg.sv
// vector types only; all widths come from hdu_config.svh, which must be on the include path
`include "hdu_config.svh"

package hdu_pkg;

    // architectural register index, x0 is never tracked
    typedef logic [`HDU_REG_ADDR_W-1:0] reg_addr_t;

    // commit id, doubles as the scoreboard slot number
    typedef logic [`HDU_SLOT_ID_W-1:0] slot_id_t;

    // one bit per scoreboard slot
    typedef logic [`HDU_SLOTS-1:0] slot_mask_t;

    // execution unit code, see HDU_EXU_* macros
    typedef logic [`HDU_EXU_W-1:0] exu_type_t;

    // issue vector: bit0 is inst1, bit1 is inst2
    typedef logic [1:0] issue_t;

endpackage

//--- rtl/hdu_scoreboard.sv
// slot_rd_o/slot_exu_o hold stale data for free slots, qualify them with slot_valid_o
`timescale 1ns/1ps
`include "hdu_config.svh"

module hdu_scoreboard (
    input  logic                clk,
    input  logic                rst_n,
    input  hdu_pkg::issue_t     issue_i,
    input  logic [1:0]          rd_track_i,
    input  hdu_pkg::slot_id_t   alloc1_id_i,
    input  hdu_pkg::slot_id_t   alloc2_id_i,
    input  hdu_pkg::reg_addr_t  inst1_rd_i,
    input  hdu_pkg::reg_addr_t  inst2_rd_i,
    input  hdu_pkg::exu_type_t  inst1_exu_i,
    input  hdu_pkg::exu_type_t  inst2_exu_i,
    input  logic                commit_valid_i,
    input  logic                commit2_valid_i,
    input  hdu_pkg::slot_id_t   commit_id_i,
    input  hdu_pkg::slot_id_t   commit2_id_i,
    output hdu_pkg::slot_mask_t slot_valid_o,
    output hdu_pkg::reg_addr_t  slot_rd_o  [`HDU_SLOTS],
    output hdu_pkg::exu_type_t  slot_exu_o [`HDU_SLOTS],
    output logic                lock_o
);
    import hdu_pkg::*;

    slot_mask_t set_mask;   // slots claimed by this cycle's issue
    slot_mask_t clr_mask;   // slots freed by commits
    logic       wr1;
    logic       wr2;

    // only issued writers of a real rd occupy a slot
    assign wr1 = issue_i[0] & rd_track_i[0];
    assign wr2 = issue_i[1] & rd_track_i[1];

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (wr1) begin
            set_mask[alloc1_id_i] = 1'b1;
        end
        if (wr2) begin
            set_mask[alloc2_id_i] = 1'b1;
        end
        if (commit_valid_i) begin
            clr_mask[commit_id_i] = 1'b1;
        end
        if (commit2_valid_i) begin
            clr_mask[commit2_id_i] = 1'b1;
        end
    end

    // set applied after clear, so an allocation beats a commit on the same slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid_o <= '0;
        end else begin
            slot_valid_o <= (slot_valid_o & ~clr_mask) | set_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (wr1) begin
            slot_rd_o[alloc1_id_i]  <= inst1_rd_i;
            slot_exu_o[alloc1_id_i] <= inst1_exu_i;
        end
        if (wr2) begin   // ids differ from inst1 whenever both issue
            slot_rd_o[alloc2_id_i]  <= inst2_rd_i;
            slot_exu_o[alloc2_id_i] <= inst2_exu_i;
        end
    end

    // any long instruction still in flight
    assign lock_o = |slot_valid_o;

endmodule

//--- rtl/hdu_slot_alloc.sv
// purely combinational; ids come from the registered valid bits, so freed slots show up a cycle late
`timescale 1ns/1ps
`include "hdu_config.svh"

module hdu_slot_alloc (
    input  hdu_pkg::slot_mask_t slot_valid_i,
    input  logic                inst1_valid_i,
    input  logic                inst2_valid_i,
    output hdu_pkg::slot_id_t   next_id1_o,
    output hdu_pkg::slot_id_t   next_id2_o,
    output logic                can_alloc_o
);
    import hdu_pkg::*;

    localparam int CNT_W = $clog2(`HDU_SLOTS + 1);

    logic [CNT_W-1:0] used_cnt;
    slot_id_t         first_free;
    slot_id_t         second_free;
    logic             found1;
    logic             found2;

    // occupancy count
    always_comb begin
        used_cnt = '0;
        for (int n = 0; n < `HDU_SLOTS; n++) begin
            used_cnt = used_cnt + CNT_W'(slot_valid_i[n]);
        end
    end

    assign can_alloc_o = (used_cnt <= CNT_W'(`HDU_SLOTS - `HDU_MIN_FREE));

    // lowest free slot
    always_comb begin
        first_free = '0;
        found1     = 1'b0;
        for (int n = 0; n < `HDU_SLOTS; n++) begin
            if (!found1 && !slot_valid_i[n]) begin
                first_free = slot_id_t'(n);
                found1     = 1'b1;
            end
        end
    end

    // next free after first_free, wrapping; id arithmetic wraps at HDU_SLOTS
    always_comb begin
        slot_id_t idx;
        second_free = '0;
        found2      = 1'b0;
        for (int k = 1; k < `HDU_SLOTS; k++) begin
            idx = first_free + slot_id_t'(k);
            if (!found2 && !slot_valid_i[idx]) begin
                second_free = idx;
                found2      = 1'b1;
            end
        end
    end

    // scan base is the raw first free slot, not the gated inst1 id
    assign next_id1_o = inst1_valid_i ? first_free : '0;
    assign next_id2_o = (inst2_valid_i && can_alloc_o) ? second_free : '0;

endmodule

//--- rtl/hdu_hazard_check.sv
// slots under commit this cycle are treated as free; pair WAW ignores the unit type
`timescale 1ns/1ps
`include "hdu_config.svh"

module hdu_hazard_check (
    input  logic                inst1_valid_i,
    input  hdu_pkg::reg_addr_t  inst1_rd_i,
    input  hdu_pkg::reg_addr_t  inst1_rs1_i,
    input  hdu_pkg::reg_addr_t  inst1_rs2_i,
    input  logic                inst1_rd_we_i,
    input  hdu_pkg::exu_type_t  inst1_exu_i,
    input  logic                inst2_valid_i,
    input  hdu_pkg::reg_addr_t  inst2_rd_i,
    input  hdu_pkg::reg_addr_t  inst2_rs1_i,
    input  hdu_pkg::reg_addr_t  inst2_rs2_i,
    input  logic                inst2_rd_we_i,
    input  hdu_pkg::exu_type_t  inst2_exu_i,
    input  hdu_pkg::slot_mask_t slot_valid_i,
    input  hdu_pkg::reg_addr_t  slot_rd_i  [`HDU_SLOTS],
    input  hdu_pkg::exu_type_t  slot_exu_i [`HDU_SLOTS],
    input  logic                commit_valid_i,
    input  logic                commit2_valid_i,
    input  hdu_pkg::slot_id_t   commit_id_i,
    input  hdu_pkg::slot_id_t   commit2_id_i,
    output logic                haz1_fifo_o,
    output logic                haz2_fifo_o,
    output logic                haz_pair_o,
    output logic [1:0]          rd_track_o
);
    import hdu_pkg::*;

    slot_mask_t slot_live;   // valid and not committing now
    slot_mask_t raw1_vec;
    slot_mask_t raw2_vec;
    slot_mask_t waw1_vec;
    slot_mask_t waw2_vec;
    logic       pair_raw;
    logic       pair_waw;

    // a valid reader with a nonzero source matching rd
    function automatic logic raw_hit(input logic vld, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input reg_addr_t rd);
        logic hit1;
        logic hit2;
        hit1 = (rs1 != '0) && (rs1 == rd);
        hit2 = (rs2 != '0) && (rs2 == rd);
        return vld && (hit1 || hit2);
    endfunction

    // same rd from a different unit could write back out of order
    function automatic logic waw_hit(input logic track, input reg_addr_t rd,
                                     input exu_type_t exu, input reg_addr_t s_rd,
                                     input exu_type_t s_exu);
        return track && (rd == s_rd) && (exu != s_exu);
    endfunction

    // x0 and non-writers never occupy a slot
    assign rd_track_o[0] = inst1_valid_i && inst1_rd_we_i && (inst1_rd_i != '0);
    assign rd_track_o[1] = inst2_valid_i && inst2_rd_we_i && (inst2_rd_i != '0);

    for (genvar n = 0; n < `HDU_SLOTS; n++) begin : g_slot
        assign slot_live[n] = slot_valid_i[n]
                              && !(commit_valid_i  && (commit_id_i  == slot_id_t'(n)))
                              && !(commit2_valid_i && (commit2_id_i == slot_id_t'(n)));

        assign raw1_vec[n] = slot_live[n]
                             && raw_hit(inst1_valid_i, inst1_rs1_i, inst1_rs2_i, slot_rd_i[n]);
        assign raw2_vec[n] = slot_live[n]
                             && raw_hit(inst2_valid_i, inst2_rs1_i, inst2_rs2_i, slot_rd_i[n]);
        assign waw1_vec[n] = slot_live[n] && waw_hit(rd_track_o[0], inst1_rd_i, inst1_exu_i,
                                                     slot_rd_i[n], slot_exu_i[n]);
        assign waw2_vec[n] = slot_live[n] && waw_hit(rd_track_o[1], inst2_rd_i, inst2_exu_i,
                                                     slot_rd_i[n], slot_exu_i[n]);
    end

    assign haz1_fifo_o = |(raw1_vec | waw1_vec);
    assign haz2_fifo_o = |(raw2_vec | waw2_vec);

    // inst2 against inst1 in the same pair
    assign pair_raw   = rd_track_o[0]
                        && raw_hit(inst2_valid_i, inst2_rs1_i, inst2_rs2_i, inst1_rd_i);
    assign pair_waw   = rd_track_o[0] && rd_track_o[1] && (inst1_rd_i == inst2_rd_i);
    assign haz_pair_o = pair_raw || pair_waw;

endmodule

//--- rtl/hdu_issue_ctrl.sv
// issue decision ignores instruction valid bits; upstream drops issue bits of invalid slots
`timescale 1ns/1ps
`include "hdu_config.svh"

module hdu_issue_ctrl (
    input  logic               can_alloc_i,
    input  logic               irq_req_i,
    input  logic               inst1_jump_i,
    input  logic               inst1_branch_i,
    input  logic               haz1_fifo_i,
    input  logic               haz2_fifo_i,
    input  logic               haz_pair_i,
    input  hdu_pkg::slot_id_t  next_id1_i,
    input  hdu_pkg::slot_id_t  next_id2_i,
    output hdu_pkg::issue_t    issue_o,
    output hdu_pkg::slot_id_t  inst1_commit_id_o,
    output hdu_pkg::slot_id_t  inst2_commit_id_o
);
    import hdu_pkg::*;

    localparam issue_t ISSUE_NONE = 2'b00;
    localparam issue_t ISSUE_ONE  = 2'b01;   // inst1 only
    localparam issue_t ISSUE_BOTH = 2'b11;

    always_comb begin
        if (!can_alloc_i || irq_req_i || haz1_fifo_i) begin
            // full stall, pair held upstream
            issue_o = ISSUE_NONE;
        end else if (inst1_jump_i || inst1_branch_i) begin
            issue_o = ISSUE_ONE;             // control flow goes alone
        end else if (haz2_fifo_i || haz_pair_i) begin
            issue_o = ISSUE_ONE;             // inst2 retried next cycle
        end else begin
            issue_o = ISSUE_BOTH;
        end
    end

    // ids only mean something for issued instructions
    assign inst1_commit_id_o = issue_o[0] ? next_id1_i : '0;
    assign inst2_commit_id_o = issue_o[1] ? next_id2_i : '0;

endmodule

//--- rtl/hdu_top.sv
// issue_o and commit ids are combinational from inputs; an issue value of 11 with inst2 invalid is legal
`timescale 1ns/1ps
`include "hdu_config.svh"

module hdu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst1_valid_i,
    input  logic                inst2_valid_i,
    input  hdu_pkg::reg_addr_t  inst1_rd_i,
    input  hdu_pkg::reg_addr_t  inst1_rs1_i,
    input  hdu_pkg::reg_addr_t  inst1_rs2_i,
    input  hdu_pkg::reg_addr_t  inst2_rd_i,
    input  hdu_pkg::reg_addr_t  inst2_rs1_i,
    input  hdu_pkg::reg_addr_t  inst2_rs2_i,
    input  logic                inst1_rd_we_i,
    input  logic                inst2_rd_we_i,
    input  hdu_pkg::exu_type_t  inst1_exu_i,
    input  hdu_pkg::exu_type_t  inst2_exu_i,
    input  logic                commit_valid_i,
    input  logic                commit2_valid_i,
    input  hdu_pkg::slot_id_t   commit_id_i,
    input  hdu_pkg::slot_id_t   commit2_id_i,
    input  logic                irq_req_i,
    input  logic                inst1_jump_i,
    input  logic                inst1_branch_i,
    output hdu_pkg::issue_t     issue_o,
    output hdu_pkg::slot_id_t   inst1_commit_id_o,
    output hdu_pkg::slot_id_t   inst2_commit_id_o,
    output logic                long_inst_lock_o
);
    import hdu_pkg::*;

    slot_mask_t slot_valid;
    reg_addr_t  slot_rd  [`HDU_SLOTS];
    exu_type_t  slot_exu [`HDU_SLOTS];
    slot_id_t   next_id1;
    slot_id_t   next_id2;
    logic       can_alloc;
    logic       haz1_fifo;
    logic       haz2_fifo;
    logic       haz_pair;
    logic [1:0] rd_track;   // per instruction: valid, writes, rd != x0

    hdu_scoreboard u_scoreboard (
        .clk             (clk),
        .rst_n           (rst_n),
        .issue_i         (issue_o),
        .rd_track_i      (rd_track),
        .alloc1_id_i     (inst1_commit_id_o),
        .alloc2_id_i     (inst2_commit_id_o),
        .inst1_rd_i      (inst1_rd_i),
        .inst2_rd_i      (inst2_rd_i),
        .inst1_exu_i     (inst1_exu_i),
        .inst2_exu_i     (inst2_exu_i),
        .commit_valid_i  (commit_valid_i),
        .commit2_valid_i (commit2_valid_i),
        .commit_id_i     (commit_id_i),
        .commit2_id_i    (commit2_id_i),
        .slot_valid_o    (slot_valid),
        .slot_rd_o       (slot_rd),
        .slot_exu_o      (slot_exu),
        .lock_o          (long_inst_lock_o)
    );

    hdu_slot_alloc u_slot_alloc (
        .slot_valid_i  (slot_valid),
        .inst1_valid_i (inst1_valid_i),
        .inst2_valid_i (inst2_valid_i),
        .next_id1_o    (next_id1),
        .next_id2_o    (next_id2),
        .can_alloc_o   (can_alloc)
    );

    hdu_hazard_check u_hazard_check (
        .inst1_valid_i   (inst1_valid_i),
        .inst1_rd_i      (inst1_rd_i),
        .inst1_rs1_i     (inst1_rs1_i),
        .inst1_rs2_i     (inst1_rs2_i),
        .inst1_rd_we_i   (inst1_rd_we_i),
        .inst1_exu_i     (inst1_exu_i),
        .inst2_valid_i   (inst2_valid_i),
        .inst2_rd_i      (inst2_rd_i),
        .inst2_rs1_i     (inst2_rs1_i),
        .inst2_rs2_i     (inst2_rs2_i),
        .inst2_rd_we_i   (inst2_rd_we_i),
        .inst2_exu_i     (inst2_exu_i),
        .slot_valid_i    (slot_valid),
        .slot_rd_i       (slot_rd),
        .slot_exu_i      (slot_exu),
        .commit_valid_i  (commit_valid_i),
        .commit2_valid_i (commit2_valid_i),
        .commit_id_i     (commit_id_i),
        .commit2_id_i    (commit2_id_i),
        .haz1_fifo_o     (haz1_fifo),
        .haz2_fifo_o     (haz2_fifo),
        .haz_pair_o      (haz_pair),
        .rd_track_o      (rd_track)
    );

    hdu_issue_ctrl u_issue_ctrl (
        .can_alloc_i       (can_alloc),
        .irq_req_i         (irq_req_i),
        .inst1_jump_i      (inst1_jump_i),
        .inst1_branch_i    (inst1_branch_i),
        .haz1_fifo_i       (haz1_fifo),
        .haz2_fifo_i       (haz2_fifo),
        .haz_pair_i        (haz_pair),
        .next_id1_i        (next_id1),
        .next_id2_i        (next_id2),
        .issue_o           (issue_o),
        .inst1_commit_id_o (inst1_commit_id_o),
        .inst2_commit_id_o (inst2_commit_id_o)
    );

endmodule

//--- dv/hdu_tb.sv
// self-checking against a reference scoreboard; random rd range is kept small to provoke hazards
`timescale 1ns/1ps
`include "hdu_config.svh"

module hdu_tb;
    import hdu_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int WATCHDOG_NS     =
        2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20) * CLK_PERIOD;

    logic      clk;
    logic      rst_n;
    logic      inst1_valid;
    logic      inst2_valid;
    reg_addr_t inst1_rd;
    reg_addr_t inst1_rs1;
    reg_addr_t inst1_rs2;
    reg_addr_t inst2_rd;
    reg_addr_t inst2_rs1;
    reg_addr_t inst2_rs2;
    logic      inst1_rd_we;
    logic      inst2_rd_we;
    exu_type_t inst1_exu;
    exu_type_t inst2_exu;
    logic      commit_valid;
    logic      commit2_valid;
    slot_id_t  commit_id;
    slot_id_t  commit2_id;
    logic      irq_req;
    logic      inst1_jump;
    logic      inst1_branch;
    issue_t    issue_o;
    slot_id_t  inst1_commit_id;
    slot_id_t  inst2_commit_id;
    logic      lock_o;

    // reference scoreboard
    slot_mask_t m_valid;
    reg_addr_t  m_rd  [`HDU_SLOTS];
    exu_type_t  m_exu [`HDU_SLOTS];
    issue_t     exp_issue;
    slot_id_t   exp_id1;
    slot_id_t   exp_id2;
    logic       exp_lock;

    string       cur_test;
    int          errors;
    int          test_errs0;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lcg_state;

    hdu_top UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst1_valid_i     (inst1_valid),
        .inst2_valid_i     (inst2_valid),
        .inst1_rd_i        (inst1_rd),
        .inst1_rs1_i       (inst1_rs1),
        .inst1_rs2_i       (inst1_rs2),
        .inst2_rd_i        (inst2_rd),
        .inst2_rs1_i       (inst2_rs1),
        .inst2_rs2_i       (inst2_rs2),
        .inst1_rd_we_i     (inst1_rd_we),
        .inst2_rd_we_i     (inst2_rd_we),
        .inst1_exu_i       (inst1_exu),
        .inst2_exu_i       (inst2_exu),
        .commit_valid_i    (commit_valid),
        .commit2_valid_i   (commit2_valid),
        .commit_id_i       (commit_id),
        .commit2_id_i      (commit2_id),
        .irq_req_i         (irq_req),
        .inst1_jump_i      (inst1_jump),
        .inst1_branch_i    (inst1_branch),
        .issue_o           (issue_o),
        .inst1_commit_id_o (inst1_commit_id),
        .inst2_commit_id_o (inst2_commit_id),
        .long_inst_lock_o  (lock_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // true when either nonzero source reads rd
    function automatic logic sources_match(input reg_addr_t rs1, input reg_addr_t rs2,
                                           input reg_addr_t rd);
        return ((rs1 != '0) && (rs1 == rd)) || ((rs2 != '0) && (rs2 == rd));
    endfunction

    always_comb begin
        slot_mask_t live;
        logic       trk1;
        logic       trk2;
        logic       h1;
        logic       h2;
        logic       hp;
        logic       can;
        int         used;
        slot_id_t   first;
        slot_id_t   second;
        slot_id_t   idx;
        logic       got1;
        logic       got2;
        trk1 = inst1_valid && inst1_rd_we && (inst1_rd != '0);
        trk2 = inst2_valid && inst2_rd_we && (inst2_rd != '0);
        h1   = 1'b0;
        h2   = 1'b0;
        used = 0;
        for (int n = 0; n < `HDU_SLOTS; n++) begin
            live[n] = m_valid[n] && !(commit_valid && commit_id == slot_id_t'(n))
                      && !(commit2_valid && commit2_id == slot_id_t'(n));
            if (live[n]) begin
                h1 = h1 || (inst1_valid && sources_match(inst1_rs1, inst1_rs2, m_rd[n]))
                        || (trk1 && inst1_rd == m_rd[n] && inst1_exu != m_exu[n]);
                h2 = h2 || (inst2_valid && sources_match(inst2_rs1, inst2_rs2, m_rd[n]))
                        || (trk2 && inst2_rd == m_rd[n] && inst2_exu != m_exu[n]);
            end
            if (m_valid[n]) used++;
        end
        hp  = (trk1 && inst2_valid && sources_match(inst2_rs1, inst2_rs2, inst1_rd))
              || (trk1 && trk2 && inst1_rd == inst2_rd);
        can = (used <= `HDU_SLOTS - `HDU_MIN_FREE);
        first = '0;
        got1  = 1'b0;
        for (int n = 0; n < `HDU_SLOTS; n++) begin
            if (!got1 && !m_valid[n]) begin
                first = slot_id_t'(n);
                got1  = 1'b1;
            end
        end
        second = '0;
        got2   = 1'b0;
        for (int k = 1; k < `HDU_SLOTS; k++) begin
            idx = first + slot_id_t'(k);   // wraps past the last slot
            if (!got2 && !m_valid[idx]) begin
                second = idx;
                got2   = 1'b1;
            end
        end
        if (!can || irq_req || h1) exp_issue = 2'b00;
        else if (inst1_jump || inst1_branch) exp_issue = 2'b01;
        else if (h2 || hp) exp_issue = 2'b01;
        else exp_issue = 2'b11;
        exp_id1  = (exp_issue[0] && inst1_valid) ? first : '0;
        exp_id2  = (exp_issue[1] && inst2_valid) ? second : '0;
        exp_lock = |m_valid;
    end

    // commits clear first, then allocations set
    always_ff @(posedge clk or negedge rst_n) begin
        slot_mask_t nv;
        if (!rst_n) begin
            m_valid <= '0;
        end else begin
            nv = m_valid;
            if (commit_valid) nv[commit_id] = 1'b0;
            if (commit2_valid) nv[commit2_id] = 1'b0;
            if (exp_issue[0] && inst1_valid && inst1_rd_we && inst1_rd != '0) begin
                nv[exp_id1]     = 1'b1;
                m_rd[exp_id1]  <= inst1_rd;
                m_exu[exp_id1] <= inst1_exu;
            end
            if (exp_issue[1] && inst2_valid && inst2_rd_we && inst2_rd != '0) begin
                nv[exp_id2]     = 1'b1;
                m_rd[exp_id2]  <= inst2_rd;
                m_exu[exp_id2] <= inst2_exu;
            end
            m_valid <= nv;
        end
    end

    task automatic note_mismatch(input string what, input int expv, input int actv);
        errors++;
        $display("Mismatch in %s: %s expected %0d actual %0d", cur_test, what, expv, actv);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) issue_o == exp_issue)
        else note_mismatch("issue_o", int'($sampled(exp_issue)), int'($sampled(issue_o)));
    assert property (@(posedge clk) disable iff (!rst_n) inst1_commit_id == exp_id1)
        else note_mismatch("inst1 id", int'($sampled(exp_id1)), int'($sampled(inst1_commit_id)));
    assert property (@(posedge clk) disable iff (!rst_n) inst2_commit_id == exp_id2)
        else note_mismatch("inst2 id", int'($sampled(exp_id2)), int'($sampled(inst2_commit_id)));
    assert property (@(posedge clk) disable iff (!rst_n) lock_o == exp_lock)
        else note_mismatch("lock", int'($sampled(exp_lock)), int'($sampled(lock_o)));

    // values straight from the issue rules, settled mid cycle
    task automatic check_outputs(input issue_t ei, input slot_id_t e1, input slot_id_t e2);
        #1;
        assert (issue_o == ei) else note_mismatch("issue_o", int'(ei), int'(issue_o));
        assert (inst1_commit_id == e1)
            else note_mismatch("inst1 id", int'(e1), int'(inst1_commit_id));
        assert (inst2_commit_id == e2)
            else note_mismatch("inst2 id", int'(e2), int'(inst2_commit_id));
    endtask

    task automatic check_lock(input logic el);
        #1;
        assert (lock_o == el) else note_mismatch("lock", int'(el), int'(lock_o));
    endtask

    task automatic set_inst1(input logic v, input logic we, input reg_addr_t rd,
                             input reg_addr_t rs1, input reg_addr_t rs2, input exu_type_t exu);
        inst1_valid = v;
        inst1_rd_we = we;
        inst1_rd    = rd;
        inst1_rs1   = rs1;
        inst1_rs2   = rs2;
        inst1_exu   = exu;
    endtask

    task automatic set_inst2(input logic v, input logic we, input reg_addr_t rd,
                             input reg_addr_t rs1, input reg_addr_t rs2, input exu_type_t exu);
        inst2_valid = v;
        inst2_rd_we = we;
        inst2_rd    = rd;
        inst2_rs1   = rs1;
        inst2_rs2   = rs2;
        inst2_exu   = exu;
    endtask

    task automatic set_commits(input logic v1, input slot_id_t id1,
                               input logic v2, input slot_id_t id2);
        commit_valid  = v1;
        commit_id     = id1;
        commit2_valid = v2;
        commit2_id    = id2;
    endtask

    task automatic set_ctrl(input logic irq, input logic jmp, input logic br);
        irq_req      = irq;
        inst1_jump   = jmp;
        inst1_branch = br;
    endtask

    task automatic idle_inputs();
        set_inst1(1'b0, 1'b0, '0, '0, '0, `HDU_EXU_ALU);
        set_inst2(1'b0, 1'b0, '0, '0, '0, `HDU_EXU_ALU);
        set_commits(1'b0, '0, 1'b0, '0);
        set_ctrl(1'b0, 1'b0, 1'b0);
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_errs0 = errors;
        idle_inputs();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errs0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - test_errs0);
        end
        idle_inputs();
        @(negedge clk);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic randomize_inputs();
        logic [31:0] a;
        logic [31:0] b;
        a = lcg_next();
        b = lcg_next();
        set_inst1(a[0], a[1], reg_addr_t'(a[4:2]), reg_addr_t'(a[7:5]),
                  reg_addr_t'(a[10:8]), exu_type_t'(a[12:11]));
        set_inst2(a[13], a[14], reg_addr_t'(a[17:15]), reg_addr_t'(a[20:18]),
                  reg_addr_t'(a[23:21]), exu_type_t'(a[25:24]));
        // commits mostly aim at pending slots
        set_commits(b[0] && m_valid[b[3:1]], slot_id_t'(b[3:1]),
                    b[4] && m_valid[b[7:5]], slot_id_t'(b[7:5]));
        set_ctrl(b[11:8] == 4'd0, b[14:12] == 3'd0, b[17:15] == 3'd0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lcg_state    = 32'h389def3b;
        cur_test     = "reset";
        rst_n        = 1'b0;
        idle_inputs();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_fill");
        check_lock(1'b0);
        @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            set_inst1(1'b1, 1'b1, reg_addr_t'(2 * k + 1), '0, '0, `HDU_EXU_ALU);
            set_inst2(1'b1, 1'b1, reg_addr_t'(2 * k + 2), '0, '0, `HDU_EXU_ALU);
            check_outputs(2'b11, slot_id_t'(2 * k), slot_id_t'(2 * k + 1));
            @(negedge clk);
        end
        check_outputs(2'b00, '0, '0);   // table full
        check_lock(1'b1);
        @(negedge clk);
        end_test();

        start_test("allocation");
        set_inst1(1'b1, 1'b1, 5'd20, '0, '0, `HDU_EXU_ALU);
        set_inst2(1'b1, 1'b1, 5'd21, '0, '0, `HDU_EXU_ALU);
        set_commits(1'b1, 3'd3, 1'b1, 3'd5);
        check_outputs(2'b00, '0, '0);   // freed slots not yet visible
        @(negedge clk);
        set_commits(1'b0, '0, 1'b0, '0);
        check_outputs(2'b11, 3'd3, 3'd5);
        @(negedge clk);
        idle_inputs();
        for (int k = 0; k < 4; k++) begin
            set_commits(1'b1, slot_id_t'(2 * k), 1'b1, slot_id_t'(2 * k + 1));
            @(negedge clk);
        end
        set_commits(1'b0, '0, 1'b0, '0);
        check_lock(1'b0);
        @(negedge clk);
        end_test();

        start_test("raw_waw");
        set_inst1(1'b1, 1'b1, 5'd5, '0, '0, `HDU_EXU_MUL);
        check_outputs(2'b11, 3'd0, '0);
        @(negedge clk);
        set_inst1(1'b1, 1'b0, '0, 5'd5, '0, `HDU_EXU_ALU);
        check_outputs(2'b00, '0, '0);
        @(negedge clk);
        set_inst1(1'b1, 1'b0, '0, '0, '0, `HDU_EXU_ALU);
        set_inst2(1'b1, 1'b0, '0, '0, 5'd5, `HDU_EXU_ALU);
        check_outputs(2'b01, 3'd1, '0);
        @(negedge clk);
        set_inst2(1'b0, 1'b0, '0, '0, '0, `HDU_EXU_ALU);
        set_inst1(1'b1, 1'b0, '0, 5'd5, '0, `HDU_EXU_ALU);
        set_commits(1'b1, 3'd0, 1'b0, '0);   // bypass lifts the stall
        check_outputs(2'b11, 3'd1, '0);
        @(negedge clk);
        set_commits(1'b0, '0, 1'b0, '0);
        set_inst1(1'b1, 1'b1, '0, '0, '0, `HDU_EXU_DIV);
        set_inst2(1'b1, 1'b0, '0, '0, '0, `HDU_EXU_ALU);
        check_outputs(2'b11, 3'd0, 3'd1);
        @(negedge clk);
        set_inst2(1'b0, 1'b0, '0, '0, '0, `HDU_EXU_ALU);
        set_inst1(1'b1, 1'b1, 5'd5, '0, '0, `HDU_EXU_MUL);
        check_outputs(2'b11, 3'd0, '0);
        @(negedge clk);
        check_outputs(2'b11, 3'd1, '0);   // same unit, no WAW stall
        @(negedge clk);
        set_inst1(1'b1, 1'b1, 5'd5, '0, '0, `HDU_EXU_DIV);
        check_outputs(2'b00, '0, '0);
        @(negedge clk);
        idle_inputs();
        set_commits(1'b1, 3'd0, 1'b1, 3'd1);
        @(negedge clk);
        end_test();

        start_test("pair_dependency");
        set_inst1(1'b1, 1'b1, 5'd9, '0, '0, `HDU_EXU_ALU);
        set_inst2(1'b1, 1'b0, '0, 5'd9, '0, `HDU_EXU_ALU);
        check_outputs(2'b01, 3'd0, '0);
        @(negedge clk);
        set_inst1(1'b1, 1'b1, 5'd11, '0, '0, `HDU_EXU_ALU);
        set_inst2(1'b1, 1'b1, 5'd11, '0, '0, `HDU_EXU_ALU);
        check_outputs(2'b01, 3'd1, '0);
        @(negedge clk);
        idle_inputs();
        set_commits(1'b1, 3'd0, 1'b1, 3'd1);
        @(negedge clk);
        end_test();

        start_test("control_priority");
        set_inst1(1'b1, 1'b1, 5'd3, '0, '0, `HDU_EXU_ALU);
        check_outputs(2'b11, 3'd0, '0);   // park a writer in slot 0, free ids start at 1
        @(negedge clk);
        set_inst1(1'b1, 1'b0, '0, 5'd1, '0, `HDU_EXU_ALU);
        set_inst2(1'b1, 1'b0, '0, 5'd2, '0, `HDU_EXU_ALU);
        set_ctrl(1'b1, 1'b0, 1'b0);
        check_outputs(2'b00, '0, '0);
        @(negedge clk);
        set_ctrl(1'b0, 1'b1, 1'b0);
        check_outputs(2'b01, 3'd1, '0);
        @(negedge clk);
        set_ctrl(1'b0, 1'b0, 1'b1);
        check_outputs(2'b01, 3'd1, '0);
        @(negedge clk);
        idle_inputs();
        set_commits(1'b1, 3'd0, 1'b0, '0);
        @(negedge clk);
        end_test();

        start_test("random");
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            randomize_inputs();
            @(negedge clk);
        end
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
rtl/hdu_pkg.sv
rtl/hdu_scoreboard.sv
rtl/hdu_slot_alloc.sv
rtl/hdu_hazard_check.sv
rtl/hdu_issue_ctrl.sv
rtl/hdu_top.sv
dv/hdu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the hdu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module hdu_tb \
    -Mdir obj_dir \
    -o hdu_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/hdu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
